// File: source/arp_settings.svh
`ifndef ARP_SETTINGS_SVH
`define ARP_SETTINGS_SVH

// number of IPv4 hosts answered on the shared port
`define ARP_NUM_HOSTS 4

// ARP header for Ethernet / IPv4, htype through tpa
`define ARP_HEAD_BYTES 28

`define ARP_ETHERTYPE 16'h0806

`endif

// File: source/eth_pkg.sv
`default_nettype none

package eth_pkg;

	typedef logic [47:0] mac_t;

	// one receive cycle from the MAC
	// frame_start marks the first data byte of a frame
	typedef struct packed {
		logic frame_start;
		logic [15:0] ethertype;  // ethertype of the current frame
		logic valid;
		logic [7:0] data;
		logic err;               // byte arrived damaged
	} eth_rx_beat_t;

	// one transmit cycle toward the MAC, addressing travels with every byte
	typedef struct packed {
		logic valid;
		logic last;
		logic [7:0] data;
		mac_t dmac;
		mac_t smac;
		logic [15:0] ethertype;
	} eth_tx_beat_t;

endpackage

`default_nettype wire

// File: source/arp_pkg.sv
`default_nettype none
`include "arp_settings.svh"

package arp_pkg;

	typedef logic [31:0] ip_t;

	// field order follows the wire order, htype high byte first
	typedef struct packed {
		logic [15:0] htype;
		logic [15:0] ptype;
		logic [7:0] hlen;
		logic [7:0] plen;
		logic [15:0] oper;
		eth_pkg::mac_t sha;
		ip_t spa;
		eth_pkg::mac_t tha;
		ip_t tpa;
	} arp_fields_t;

	// same header as bytes, b[`ARP_HEAD_BYTES-1] is the first byte on the wire
	typedef union packed {
		arp_fields_t f;
		logic [`ARP_HEAD_BYTES-1:0][7:0] b;
	} arp_head_u;

	parameter logic [15:0] op_request = 16'd1;
	parameter logic [15:0] op_reply = 16'd2;

	// ethernet hardware, IPv4 protocol
	parameter logic [15:0] htype_eth = 16'd1;
	parameter logic [15:0] ptype_ipv4 = 16'h0800;
	parameter logic [7:0] hlen_eth = 8'd6;
	parameter logic [7:0] plen_ipv4 = 8'd4;

endpackage

`default_nettype wire

// File: source/arp_rx_fanout.sv
`timescale 1ns/1ns
`default_nettype none
`include "arp_settings.svh"

// single register stage shared by all responders
module arp_rx_fanout (
	input logic clk,
	input logic reset,
	input eth_pkg::eth_rx_beat_t rx,
	output eth_pkg::eth_rx_beat_t rx_q,
	output logic arp_start
);

	logic is_arp;

	// decode on the raw input so arp_start lines up with rx_q
	assign is_arp = rx.frame_start && (rx.ethertype == `ARP_ETHERTYPE);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rx_q <= '0;
			arp_start <= 1'b0;
		end else begin
			rx_q <= rx;
			arp_start <= is_arp;  // only ARP frames wake the responders
		end
	end

endmodule

`default_nettype wire

// File: source/arp_responder.sv
`timescale 1ns/1ns
`default_nettype none
`include "arp_settings.svh"

module arp_responder (
	input logic clk,
	input logic reset,
	input eth_pkg::eth_rx_beat_t rx_q,
	input logic arp_start,
	input eth_pkg::mac_t own_mac,
	input arp_pkg::ip_t own_ip,
	input logic ack,
	output logic req,
	output eth_pkg::eth_tx_beat_t tx
);

	localparam int cnt_w = $clog2(`ARP_HEAD_BYTES);
	localparam logic [cnt_w-1:0] last_byte = cnt_w'(`ARP_HEAD_BYTES - 1);

	typedef enum logic [1:0] {
		st_idle,
		st_head,
		st_payload,
		st_tail
	} rx_state_t;

	rx_state_t state;
	logic [cnt_w-1:0] rx_cnt;     // header bytes taken so far
	logic frame_err;
	arp_pkg::arp_head_u head;
	arp_pkg::arp_head_u reply;
	logic sending;
	logic [cnt_w-1:0] tx_cnt;     // byte index into reply, counts down
	logic take;
	logic match;

	// the frame_start beat already carries the first header byte
	assign take = rx_q.valid &&
		(state == st_head || (arp_start && (state == st_idle || state == st_tail)));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			rx_cnt <= '0;
			frame_err <= 1'b0;
		end else begin
			case (state)
				// tail also accepts a new frame, gaps can be a single cycle
				st_idle, st_tail: begin
					if (arp_start) begin
						state <= st_head;
						rx_cnt <= rx_q.valid ? cnt_w'(1) : '0;
						frame_err <= rx_q.valid && rx_q.err;
					end else begin
						state <= st_idle;
					end
				end
				st_head: begin
					if (rx_q.valid) begin
						frame_err <= frame_err | rx_q.err;
						rx_cnt <= rx_cnt + 1'b1;
						if (rx_cnt == last_byte)
							state <= st_payload;
					end
				end
				st_payload: begin
					// payload bytes are dropped, only their err flags count
					if (rx_q.valid)
						frame_err <= frame_err | rx_q.err;
					else
						state <= st_tail;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			head.b <= {head.b[`ARP_HEAD_BYTES-2:0], rx_q.data};  // first byte ends on top
	end

	// a second request while one reply is still out is lost
	assign match = (state == st_tail) && !frame_err &&
		(head.f.tpa == own_ip) &&
		(head.f.oper == arp_pkg::op_request) &&
		!req && !sending;

	always_ff @(posedge clk) begin
		if (match) begin
			reply.f.htype <= arp_pkg::htype_eth;
			reply.f.ptype <= arp_pkg::ptype_ipv4;
			reply.f.hlen <= arp_pkg::hlen_eth;
			reply.f.plen <= arp_pkg::plen_ipv4;
			reply.f.oper <= arp_pkg::op_reply;
			reply.f.sha <= own_mac;
			reply.f.spa <= own_ip;
			reply.f.tha <= head.f.sha;  // answer goes back to the asker
			reply.f.tpa <= head.f.spa;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			req <= 1'b0;
			sending <= 1'b0;
			tx_cnt <= '0;
		end else begin
			if (match)
				req <= 1'b1;
			else if (ack)
				req <= 1'b0;

			if (ack) begin
				sending <= 1'b1;
				tx_cnt <= last_byte;
			end else if (sending) begin
				if (tx_cnt == '0)
					sending <= 1'b0;
				else
					tx_cnt <= tx_cnt - 1'b1;
			end
		end
	end

	always_comb begin
		tx.valid = sending;
		tx.last = sending && (tx_cnt == '0);
		tx.data = reply.b[tx_cnt];
		tx.dmac = reply.f.tha;
		tx.smac = own_mac;
		tx.ethertype = `ARP_ETHERTYPE;
	end

endmodule

`default_nettype wire

// File: source/arp_tx_arbiter.sv
`timescale 1ns/1ns
`default_nettype none
`include "arp_settings.svh"

module arp_tx_arbiter (
	input logic clk,
	input logic reset,
	input logic [`ARP_NUM_HOSTS-1:0] req,
	input eth_pkg::eth_tx_beat_t [`ARP_NUM_HOSTS-1:0] beats,
	output logic [`ARP_NUM_HOSTS-1:0] ack,
	output eth_pkg::eth_tx_beat_t tx
);

	localparam int idx_w = (`ARP_NUM_HOSTS > 1) ? $clog2(`ARP_NUM_HOSTS) : 1;

	logic busy;
	logic [idx_w-1:0] gnt;
	logic [`ARP_NUM_HOSTS-1:0] pick;
	logic [idx_w-1:0] pick_idx;
	eth_pkg::eth_tx_beat_t cur;

	// lowest index wins, scan from the top so the last hit is kept
	always_comb begin
		pick = '0;
		pick_idx = '0;
		for (int i = `ARP_NUM_HOSTS - 1; i >= 0; i--) begin
			if (req[i]) begin
				pick = '0;
				pick[i] = 1'b1;
				pick_idx = idx_w'(i);
			end
		end
	end

	assign ack = busy ? '0 : pick;  // one-cycle pulse, busy drops it
	assign cur = beats[gnt];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			gnt <= '0;
		end else if (!busy) begin
			if (|pick) begin
				busy <= 1'b1;
				gnt <= pick_idx;
			end
		end else if (cur.valid && cur.last) begin
			busy <= 1'b0;  // free again while the last byte is on tx
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tx <= '0;
		end else if (busy) begin
			tx <= cur;
		end else begin
			tx.valid <= 1'b0;
			tx.last <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: source/arp_multihost.sv
`timescale 1ns/1ns
`default_nettype none
`include "arp_settings.svh"

module arp_multihost (
	input logic clk,
	input logic reset,
	input eth_pkg::eth_rx_beat_t rx,
	input eth_pkg::mac_t [`ARP_NUM_HOSTS-1:0] host_mac,
	input arp_pkg::ip_t [`ARP_NUM_HOSTS-1:0] host_ip,
	output eth_pkg::eth_tx_beat_t tx
);

	eth_pkg::eth_rx_beat_t rx_q;
	logic arp_start;
	logic [`ARP_NUM_HOSTS-1:0] req;
	logic [`ARP_NUM_HOSTS-1:0] ack;
	eth_pkg::eth_tx_beat_t [`ARP_NUM_HOSTS-1:0] beats;

	arp_rx_fanout arp_rx_fanout_i (
		.clk       (clk),
		.reset     (reset),
		.rx        (rx),
		.rx_q      (rx_q),
		.arp_start (arp_start)
	);

	// every responder sees the same stream, each answers for its own ip
	for (genvar i = 0; i < `ARP_NUM_HOSTS; i++) begin : g_host
		arp_responder arp_responder_i (
			.clk       (clk),
			.reset     (reset),
			.rx_q      (rx_q),
			.arp_start (arp_start),
			.own_mac   (host_mac[i]),
			.own_ip    (host_ip[i]),
			.ack       (ack[i]),
			.req       (req[i]),
			.tx        (beats[i])
		);
	end

	arp_tx_arbiter arp_tx_arbiter_i (
		.clk   (clk),
		.reset (reset),
		.req   (req),
		.beats (beats),
		.ack   (ack),
		.tx    (tx)
	);

endmodule

`default_nettype wire

// File: dv/arp_multihost_sva.sv
`timescale 1ns/1ns
`default_nettype none
`include "arp_settings.svh"

module arp_multihost_sva (
	input logic clk,
	input logic reset,
	input logic [`ARP_NUM_HOSTS-1:0] req,
	input logic [`ARP_NUM_HOSTS-1:0] ack,
	input eth_pkg::eth_tx_beat_t tx
);

	logic [5:0] run;  // valid beats of the current output reply before this one

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			run <= '0;
		else if (tx.valid && !tx.last)
			run <= run + 1'b1;
		else
			run <= '0;
	end

	ack_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(ack))
		else $error("ack is not one-hot");

	// a grant only goes where a request is up
	ack_to_req: assert property (@(posedge clk) disable iff (reset) (ack & ~req) == '0)
		else $error("ack without req");

	last_at_28: assert property (@(posedge clk) disable iff (reset)
		tx.last |-> (tx.valid && run == 6'(`ARP_HEAD_BYTES - 1)))
		else $error("last not on beat 28");

	no_long_run: assert property (@(posedge clk) disable iff (reset)
		(tx.valid && run == 6'(`ARP_HEAD_BYTES - 1)) |-> tx.last)
		else $error("reply longer than 28 beats");

	// valid may only fall right after last
	no_gap: assert property (@(posedge clk) disable iff (reset)
		($past(tx.valid) && !tx.valid) |-> $past(tx.last))
		else $error("reply broken before last");

	idle_after_reset: assert property (@(posedge clk) $fell(reset) |-> (!tx.valid && !tx.last))
		else $error("tx busy right after reset");

endmodule

bind arp_multihost arp_multihost_sva arp_multihost_sva_i (
	.clk   (clk),
	.reset (reset),
	.req   (req),
	.ack   (ack),
	.tx    (tx)
);

`default_nettype wire

// File: dv/arp_multihost_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "arp_settings.svh"

module arp_multihost_tb;

	localparam int num_hosts = `ARP_NUM_HOSTS;
	localparam int num_frames = 60;
	localparam int gap_max = 40;
	localparam int cycle_limit = num_frames * (gap_max + 44 + 28 * num_hosts) + 500;

	// what the model needs to know about a frame once it has ended
	typedef struct packed {
		logic qualify;
		logic [7:0] host;
		eth_pkg::mac_t sha;
		arp_pkg::ip_t spa;
	} frame_note_t;

	logic clk = 1'b0;
	logic reset;
	eth_pkg::eth_rx_beat_t rx;
	eth_pkg::mac_t [num_hosts-1:0] host_mac;
	arp_pkg::ip_t [num_hosts-1:0] host_ip;
	eth_pkg::eth_tx_beat_t tx;

	logic [31:0] lfsr;
	frame_note_t notes[$];
	logic slot_full [num_hosts];
	arp_pkg::arp_head_u exp_head [num_hosts];
	int cycles = 0;
	int value_errs = 0;
	int other_errs = 0;
	int beat_idx = 0;
	int cur_host = -1;
	int prev_host = 0;
	logic rx_valid_prev = 1'b0;
	logic dec1 = 1'b0;
	logic dec2 = 1'b0;

	arp_multihost arp_multihost_i (
		.clk      (clk),
		.reset    (reset),
		.rx       (rx),
		.host_mac (host_mac),
		.host_ip  (host_ip),
		.tx       (tx)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic string field_name(input int idx);
		if (idx < 2) return "htype";
		if (idx < 4) return "ptype";
		if (idx < 5) return "hlen";
		if (idx < 6) return "plen";
		if (idx < 8) return "oper";
		if (idx < 14) return "sha";
		if (idx < 18) return "spa";
		if (idx < 24) return "tha";
		return "tpa";
	endfunction

	function automatic bit any_pending();
		for (int i = 0; i < num_hosts; i++)
			if (slot_full[i])
				return 1'b1;
		return 1'b0;
	endfunction

	task automatic check_beat();
		if (tx.valid) begin
			if (beat_idx == 0) begin
				cur_host = -1;
				for (int i = 0; i < num_hosts; i++)
					if (tx.smac == host_mac[i])
						cur_host = i;
				assert (cur_host >= 0) else begin
					other_errs++;
					$display("reply at %0t carries an unknown source mac", $time);
				end
				if (cur_host >= 0)
					assert (slot_full[cur_host]) else begin
						other_errs++;
						$display("host %0d sent a reply nobody asked for", cur_host);
					end
			end
			if (cur_host >= 0 && slot_full[cur_host] && beat_idx < `ARP_HEAD_BYTES) begin
				assert (tx.data == exp_head[cur_host].b[`ARP_HEAD_BYTES - 1 - beat_idx]) else begin
					value_errs++;
					$display("ERR %0t %s byte %0d", $time, field_name(beat_idx), beat_idx);
				end
				assert (tx.dmac == exp_head[cur_host].f.tha) else begin
					value_errs++;
					$display("ERR %0t dmac", $time);
				end
				assert (tx.ethertype == 16'h0806) else begin
					value_errs++;
					$display("ERR %0t ethertype", $time);
				end
			end
			if (tx.last) begin
				assert (beat_idx == `ARP_HEAD_BYTES - 1) else begin
					value_errs++;
					$display("ERR %0t reply length %0d", $time, beat_idx + 1);
				end
				if (cur_host >= 0)
					slot_full[cur_host] = 1'b0;  // host may answer again from the next cycle
				beat_idx = 0;
			end else begin
				beat_idx++;
			end
		end
	endtask

	// the responder decides in its tail cycle three edges after valid is driven low
	task automatic decide_frame();
		frame_note_t n;
		logic fall;
		fall = rx_valid_prev && !rx.valid;
		rx_valid_prev = rx.valid;
		if (dec2 && notes.size() > 0) begin
			n = notes.pop_front();
			if (n.qualify && !slot_full[n.host]) begin
				exp_head[n.host].f.htype = 16'd1;
				exp_head[n.host].f.ptype = 16'h0800;
				exp_head[n.host].f.hlen = 8'd6;
				exp_head[n.host].f.plen = 8'd4;
				exp_head[n.host].f.oper = 16'd2;
				exp_head[n.host].f.sha = host_mac[n.host];
				exp_head[n.host].f.spa = host_ip[n.host];
				exp_head[n.host].f.tha = n.sha;
				exp_head[n.host].f.tpa = n.spa;
				slot_full[n.host] = 1'b1;
			end
		end
		dec2 = dec1;
		dec1 = fall;
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end else begin
			check_beat();  // a reply ending now frees its host before the decision
			decide_frame();
		end
	end

	// kinds 0 request, 1 wrong tpa, 2 op_reply, 3 not ARP, 4 err byte, 5 to a pending host
	task automatic send_frame();
		arp_pkg::arp_head_u f;
		eth_pkg::eth_rx_beat_t b;
		frame_note_t note;
		logic [15:0] etype;
		int kind;
		int host;
		int plen;
		int gap;
		int nbytes;
		int err_at;
		kind = int'(rand_bits(3) % 6);
		host = int'(rand_bits(2) % num_hosts);
		if (kind == 5)
			host = prev_host;  // its reply is still going out when this one ends
		f.f.htype = 16'd1;
		f.f.ptype = 16'h0800;
		f.f.hlen = 8'd6;
		f.f.plen = 8'd4;
		f.f.oper = (kind == 2) ? 16'd2 : 16'd1;
		f.f.sha = {16'(rand_bits(16)), rand_bits(32)};
		f.f.spa = {8'd192, 8'd168, 8'd1, 8'(rand_bits(8))};
		f.f.tha = '0;
		f.f.tpa = (kind == 1) ? (host_ip[host] ^ 32'h0000_0100) : host_ip[host];
		etype = (kind == 3) ? 16'h0800 : `ARP_ETHERTYPE;
		plen = (kind == 5) ? 0 : int'(rand_bits(4));
		gap = (kind == 5) ? 1 : int'(rand_bits(6) % gap_max) + 1;  // idle cycles before the frame
		nbytes = `ARP_HEAD_BYTES + plen;
		err_at = (kind == 4) ? int'(rand_bits(6) % nbytes) : -1;
		note.qualify = (kind == 0 || kind == 5);
		note.host = 8'(host);
		note.sha = f.f.sha;
		note.spa = f.f.spa;
		repeat (gap - 1) @(posedge clk);
		for (int i = 0; i < nbytes; i++) begin
			b.frame_start = (i == 0);
			b.ethertype = etype;
			b.valid = 1'b1;
			b.data = (i < `ARP_HEAD_BYTES) ? f.b[`ARP_HEAD_BYTES - 1 - i] : 8'(rand_bits(8));
			b.err = (i == err_at);
			@(posedge clk);
			rx <= b;
		end
		@(posedge clk);
		rx <= '0;
		notes.push_back(note);
		prev_host = host;
	endtask

	initial begin
		lfsr = 32'he9;
		reset = 1'b1;
		rx = '0;
		for (int i = 0; i < num_hosts; i++) begin
			host_mac[i] = 48'h02_00_00_00_00_00 | 48'(i);
			host_ip[i] = {8'd10, 8'd0, 8'd0, 8'(i + 1)};
			slot_full[i] = 1'b0;
		end
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		repeat (4) @(posedge clk);
		repeat (num_frames) send_frame();
		repeat (4) @(posedge clk);  // last decision is still in flight
		for (int w = 0; w < 2 * 32 * num_hosts && any_pending(); w++)
			@(negedge clk);
		for (int i = 0; i < num_hosts; i++)
			if (slot_full[i]) begin
				other_errs++;
				$display("host %0d: expected reply never sent", i);
			end
		$display("errors: %0d value, %0d other", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+source
source/eth_pkg.sv
source/arp_pkg.sv
source/arp_rx_fanout.sv
source/arp_responder.sv
source/arp_tx_arbiter.sv
source/arp_multihost.sv
dv/arp_multihost_sva.sv
dv/arp_multihost_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
TOP ?= arp_multihost_tb
FILELIST ?= vlog.f
LOG ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
